//--- run_sim.sh
#!/bin/sh
# build and run the tile generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_tilegen_subsystem

verilator --binary --timing -f tilegen_subsystem.f --top-module "$TOP" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the verdict comes from the log
if grep -q "Test OK" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

//--- sim/tb_tilegen_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilegen_cfg.svh"

module tb_tilegen_subsystem import tilegen_pkg::*; ();

	localparam int H_VIS       = `TG_H_VISIBLE;
	localparam int V_VIS       = `TG_V_VISIBLE;
	localparam int FRAME_DOTS  = H_VIS * V_VIS;
	// two whole frames of dots
	localparam int FRAME_LIMIT = 2 * `TG_H_TOTAL * `TG_V_TOTAL;

	logic                  clk_6m;
	logic                  rst_n;
	logic                  cpu_we;
	logic [`TG_CPU_AW-1:0] cpu_addr;
	logic [`TG_CPU_DW-1:0] cpu_data;
	gfx_addr_t             gfx0_addr;
	gfx_row_t              gfx0_data;
	gfx_addr_t             gfx1_addr;
	gfx_row_t              gfx1_data;
	dot_t                  dot;
	logic                  dot_valid;
	logic                  hsync;
	logic                  vsync;

	integer rand_seed;

	// reference copy of what the cpu wrote
	scroll_t     ref_scroll_x [2];
	scroll_t     ref_scroll_y [2];
	logic        ref_enable [2];
	logic        ref_flip;
	dot_t        ref_back_color;
	tile_entry_t ref_map [2][64];

	tilegen_subsystem u_tilegen_subsystem (
		.clk_6m    (clk_6m),
		.rst_n     (rst_n),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_data  (cpu_data),
		.gfx0_addr (gfx0_addr),
		.gfx0_data (gfx0_data),
		.gfx1_addr (gfx1_addr),
		.gfx1_data (gfx1_data),
		.dot       (dot),
		.dot_valid (dot_valid),
		.hsync     (hsync),
		.vsync     (vsync)
	);

	////////////////////
	// graphics ROMs
	////////////////////

	// pen i of row r in tile c is (c + r + i) mod 8
	function automatic gfx_row_t rom_row(input gfx_addr_t addr);
		gfx_row_t row;
		int       code;
		int       r;
		code = int'(addr[10:3]);
		r    = int'(addr[2:0]);
		row  = '0;
		for (int i = 0; i < 8; i++) begin
			row[3*i +: 3] = pen_t'((code + r + i) % 8);
		end
		return row;
	endfunction

	assign gfx0_data = rom_row(gfx0_addr);
	assign gfx1_data = rom_row(gfx1_addr);

	initial begin
		clk_6m = 1'b0;
		forever #10 clk_6m = ~clk_6m;
	end

	////////////////////
	// failure reporting
	////////////////////

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			report_failure($sformatf("[FAIL] t=%0t %s actual=%0h expected=%0h",
				$time, name, actual, expected));
		end
	endtask

	////////////////////
	// reference model
	////////////////////

	// flip then scroll, wrapping on the 64 pixel plane
	function automatic int plane_pos(input int s, input int visible, input int scroll);
		int p;
		p = ref_flip ? (visible - 1 - s) : s;
		return (p + scroll) % 64;
	endfunction

	function automatic int map_index_at(input int l, input int sx, input int sy);
		int x;
		int y;
		x = plane_pos(sx, H_VIS, int'(ref_scroll_x[l]));
		y = plane_pos(sy, V_VIS, int'(ref_scroll_y[l]));
		return (y / 8) * 8 + x / 8;
	endfunction

	// row address is the tile code above the row inside the tile
	function automatic gfx_addr_t expected_gfx_addr(input int l, input int sx, input int sy);
		tile_entry_t entry;
		int          y;
		y     = plane_pos(sy, V_VIS, int'(ref_scroll_y[l]));
		entry = ref_map[l][map_index_at(l, sx, sy)];
		return {entry.code, 3'(y % 8)};
	endfunction

	// background, then layer 0, then layer 1, ties to the later layer
	function automatic dot_t expected_dot(input int sx, input int sy);
		dot_t        d;
		prio_t       p;
		tile_entry_t entry;
		int          x;
		int          y;
		int          pen;
		d = ref_back_color;
		p = '0;
		for (int l = 0; l < 2; l++) begin
			if (ref_enable[l]) begin
				x     = plane_pos(sx, H_VIS, int'(ref_scroll_x[l]));
				y     = plane_pos(sy, V_VIS, int'(ref_scroll_y[l]));
				entry = ref_map[l][map_index_at(l, sx, sy)];
				pen   = (int'(entry.code) + y % 8 + x % 8) % 8;
				if (pen != 0 && entry.prio >= p) begin
					d = {entry.color, pen_t'(pen)};
					p = entry.prio;
				end
			end
		end
		return d;
	endfunction

	////////////////////
	// cpu writes
	////////////////////

	// one cycle strobe, then a dead cycle
	task automatic cpu_write(input logic [`TG_CPU_AW-1:0] addr,
		input logic [`TG_CPU_DW-1:0] data);
		@(posedge clk_6m);
		cpu_we   <= 1'b1;
		cpu_addr <= addr;
		cpu_data <= data;
		@(posedge clk_6m);
		cpu_we   <= 1'b0;
	endtask

	task automatic set_scroll(input int l, input scroll_t x, input scroll_t y);
		cpu_write({2'b00, 7'((l == 0) ? `TG_REG_SCROLL_X0 : `TG_REG_SCROLL_X1)},
			{10'd0, x});
		cpu_write({2'b00, 7'((l == 0) ? `TG_REG_SCROLL_Y0 : `TG_REG_SCROLL_Y1)},
			{10'd0, y});
		ref_scroll_x[l] = x;
		ref_scroll_y[l] = y;
	endtask

	task automatic set_control(input logic f, input logic en0, input logic en1);
		cpu_write({2'b00, 7'(`TG_REG_CONTROL)}, {13'd0, en1, en0, f});
		ref_flip      = f;
		ref_enable[0] = en0;
		ref_enable[1] = en1;
	endtask

	task automatic set_back_color(input dot_t c);
		cpu_write({2'b00, 7'(`TG_REG_BACK_COLOR)}, {8'd0, c});
		ref_back_color = c;
	endtask

	task automatic write_map(input int l, input int idx, input tile_entry_t entry);
		logic [1:0] region;
		region = (l == 0) ? `TG_REGION_LAYER0 : `TG_REGION_LAYER1;
		cpu_write({region, 1'b0, map_index_t'(idx)}, entry);
		ref_map[l][idx] = entry;
	endtask

	// random code, colour and priority in both maps
	task automatic fill_maps();
		for (int l = 0; l < 2; l++) begin
			for (int i = 0; i < 64; i++) begin
				write_map(l, i, tile_entry_t'(16'($random(rand_seed))));
			end
		end
	endtask

	// layer 1 gets the priority of the layer 0 tile under this screen point
	task automatic force_tie(input int sx, input int sy);
		tile_entry_t entry;
		int          idx0;
		int          idx1;
		idx0       = map_index_at(0, sx, sy);
		idx1       = map_index_at(1, sx, sy);
		entry      = ref_map[1][idx1];
		entry.prio = ref_map[0][idx0].prio;
		write_map(1, idx1, entry);
	endtask

	////////////////////
	// frame capture
	////////////////////

	task automatic wait_vsync_fall();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk_6m);
			cycles++;
			if (cycles > FRAME_LIMIT) begin
				report_failure("timeout: vsync never went high");
			end
		end while (vsync !== 1'b1);
		cycles = 0;
		do begin
			@(negedge clk_6m);
			cycles++;
			if (cycles > FRAME_LIMIT) begin
				report_failure("timeout: vsync never went low");
			end
		end while (vsync !== 1'b0);
	endtask

	// skips to the next vsync fall, then checks dots up to the one after
	task automatic check_frame(output int n_dots, output int n_hs, output int n_vs);
		int        cycles;
		int        sx;
		int        sy;
		logic      hs_prev;
		logic      vs_prev;
		logic      done;
		// ROM addresses seen on the last three clocks, newest first
		gfx_addr_t gfx0_hist [3];
		gfx_addr_t gfx1_hist [3];
		wait_vsync_fall();
		n_dots  = 0;
		n_hs    = 0;
		n_vs    = 0;
		cycles  = 0;
		hs_prev = 1'b0;
		vs_prev = 1'b0;
		done    = 1'b0;
		for (int i = 0; i < 3; i++) begin
			gfx0_hist[i] = '0;
			gfx1_hist[i] = '0;
		end
		while (!done) begin
			@(negedge clk_6m);
			cycles++;
			if (cycles > FRAME_LIMIT) begin
				report_failure("timeout: frame did not end with a vsync pulse");
			end
			if (dot_valid === 1'b1) begin
				// valid dots arrive in raster order
				sx = n_dots % H_VIS;
				sy = n_dots / H_VIS;
				if (n_dots < FRAME_DOTS) begin
					check_value("dot", 32'(dot), 32'(expected_dot(sx, sy)));
					// row address leaves three clocks ahead of its dot
					if (ref_enable[0]) begin
						check_value("gfx0_addr", 32'(gfx0_hist[2]),
							32'(expected_gfx_addr(0, sx, sy)));
					end
					if (ref_enable[1]) begin
						check_value("gfx1_addr", 32'(gfx1_hist[2]),
							32'(expected_gfx_addr(1, sx, sy)));
					end
				end
				n_dots++;
			end else begin
				// blanked dots carry colour 0
				check_value("blanked dot", 32'(dot), 32'd0);
			end
			gfx0_hist[2] = gfx0_hist[1];
			gfx0_hist[1] = gfx0_hist[0];
			gfx0_hist[0] = gfx0_addr;
			gfx1_hist[2] = gfx1_hist[1];
			gfx1_hist[1] = gfx1_hist[0];
			gfx1_hist[0] = gfx1_addr;
			if (hsync === 1'b1 && !hs_prev) n_hs++;
			if (vsync === 1'b1 && !vs_prev) n_vs++;
			if (vsync === 1'b0 && vs_prev) done = 1'b1;
			hs_prev = hsync;
			vs_prev = vsync;
		end
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic reset_state();
		int n_dots;
		int n_hs;
		int n_vs;
		@(negedge clk_6m);
		check_value("dot_valid", 32'(dot_valid), 32'd0);
		check_value("hsync", 32'(hsync), 32'd0);
		check_value("vsync", 32'(vsync), 32'd0);
		// layers off and black background out of reset
		wait_vsync_fall();
		check_frame(n_dots, n_hs, n_vs);
		check_value("valid dot count", 32'(n_dots), 32'(FRAME_DOTS));
	endtask

	task automatic frame_geometry();
		int n_dots;
		int n_hs;
		int n_vs;
		check_frame(n_dots, n_hs, n_vs);
		check_value("valid dot count", 32'(n_dots), 32'(FRAME_DOTS));
		check_value("hsync pulses", 32'(n_hs), 32'(`TG_V_TOTAL));
		check_value("vsync pulses", 32'(n_vs), 32'd1);
	endtask

	task automatic single_layer();
		int n_dots;
		int n_hs;
		int n_vs;
		fill_maps();
		set_scroll(0, 6'd0, 6'd0);
		set_control(1'b0, 1'b1, 1'b0);
		wait_vsync_fall();
		check_frame(n_dots, n_hs, n_vs);
		check_value("valid dot count", 32'(n_dots), 32'(FRAME_DOTS));
	endtask

	task automatic scroll_and_priority();
		int n_dots;
		int n_hs;
		int n_vs;
		set_scroll(0, 6'd13, 6'd5);
		set_scroll(1, 6'd37, 6'd50);
		set_back_color(8'h33);
		set_control(1'b0, 1'b1, 1'b1);
		// a few tiles with equal priority on both layers
		force_tie(0, 0);
		force_tie(20, 10);
		force_tie(40, 25);
		force_tie(7, 30);
		wait_vsync_fall();
		check_frame(n_dots, n_hs, n_vs);
		check_value("valid dot count", 32'(n_dots), 32'(FRAME_DOTS));
	endtask

	task automatic flip_and_background();
		int n_dots;
		int n_hs;
		int n_vs;
		set_back_color(8'h5a);
		set_control(1'b1, 1'b1, 1'b0);
		wait_vsync_fall();
		check_frame(n_dots, n_hs, n_vs);
		check_value("valid dot count", 32'(n_dots), 32'(FRAME_DOTS));
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		rst_n     = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_data  = '0;
		rand_seed = 32'h4e38_6dbd;
		// model matches the register reset values
		ref_scroll_x[0] = '0;
		ref_scroll_x[1] = '0;
		ref_scroll_y[0] = '0;
		ref_scroll_y[1] = '0;
		ref_enable[0]   = 1'b0;
		ref_enable[1]   = 1'b0;
		ref_flip        = 1'b0;
		ref_back_color  = '0;
		repeat (3) @(posedge clk_6m);
		rst_n <= 1'b1;

		reset_state();
		frame_geometry();
		single_layer();
		scroll_and_priority();
		flip_and_background();

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- tilegen_subsystem.f
+incdir+verilog
verilog/tilegen_pkg.sv
verilog/video_timing.sv
verilog/tilegen_regs.sv
verilog/tile_scroll_gen.sv
verilog/tile_pixel_mixer.sv
verilog/tilegen_subsystem.sv
sim/tb_tilegen_subsystem.sv

//--- verilog/tile_pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module tile_pixel_mixer import tilegen_pkg::*; (
	input  wire          clk_6m,
	input  wire          rst_n,
	input  mix_pixel_t   pixel_in,
	input  layer_pixel_t layer,
	output mix_pixel_t   pixel_out
);

	// layer pixel is opaque
	logic       opaque;
	// layer priority at least the incoming one
	logic       prio_ok;
	logic       layer_wins;
	mix_pixel_t mix_next;

	////////////////////
	// priority test
	////////////////////

	// enable is already folded into the pen
	assign opaque  = (layer.pen != pen_t'(0));
	// ties go to the layer, so later stages win equal priority
	assign prio_ok = (layer.prio >= pixel_in.prio);
	assign layer_wins = opaque && prio_ok;

	////////////////////
	// dot build
	////////////////////

	always_comb begin
		// tag always follows the incoming pixel
		mix_next.tag = pixel_in.tag;
		if (layer_wins) begin
			// palette bank on top, pen below
			mix_next.dot  = {layer.color, layer.pen};
			mix_next.prio = layer.prio;
		end else begin
			mix_next.dot  = pixel_in.dot;
			mix_next.prio = pixel_in.prio;
		end
		// blanking
		if (!pixel_in.tag.active) begin
			mix_next.dot = '0;
		end
	end

	////////////////////
	// output stage
	////////////////////

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			// inactive, no sync
			pixel_out <= '0;
		end else begin
			pixel_out <= mix_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/tile_scroll_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilegen_cfg.svh"

module tile_scroll_gen import tilegen_pkg::*; (
	input  wire         clk_6m,
	input  wire         rst_n,
	input  hpos_t       hcount,
	input  vpos_t       vcount,
	input  raster_tag_t tag_in,
	input  layer_ctrl_t ctrl,
	input  wire         flip,
	input  wire         map_we,
	input  map_index_t  map_addr,
	input  tile_entry_t map_data,
	output gfx_addr_t   gfx_addr,
	input  gfx_row_t    gfx_data,
	output layer_pixel_t pixel
);

	// tile map, one entry per tile of the square map
	tile_entry_t tile_ram [`TG_MAP_TILES*`TG_MAP_TILES];

	// screen position after flip
	hpos_t       scr_x;
	vpos_t       scr_y;
	// plane position after scroll, wraps at 64
	logic [5:0]  plane_x;
	logic [5:0]  plane_y;
	map_index_t  map_index;

	// stage 1
	raster_tag_t tag_s1;
	tile_entry_t entry_s1;
	logic [2:0]  fine_x_s1;
	logic [2:0]  fine_y_s1;

	// stage 2, gfx_addr is the row address register
	raster_tag_t tag_s2;
	logic [2:0]  col_s2;
	color_t      color_s2;
	prio_t       prio_s2;

	pen_t        pen_sel;

	////////////////////
	// map position
	////////////////////

	always_comb begin
		// flip mirrors the visible window in both axes
		if (flip) begin
			scr_x = hpos_t'(`TG_H_VISIBLE - 1) - hcount;
			scr_y = vpos_t'(`TG_V_VISIBLE - 1) - vcount;
		end else begin
			scr_x = hcount;
			scr_y = vcount;
		end
		plane_x = scr_x[5:0] + ctrl.scroll_x;
		plane_y = scr_y + ctrl.scroll_y;
		// row of tiles then tile in row
		map_index = {plane_y[5:3], plane_x[5:3]};
	end

	////////////////////
	// tile RAM
	////////////////////

	// cpu write port and raster read port, read is registered
	always_ff @(posedge clk_6m) begin
		if (map_we) begin
			tile_ram[map_addr] <= map_data;
		end
		entry_s1 <= tile_ram[map_index];
	end

	////////////////////
	// pipeline
	////////////////////

	// tags are control and clear on reset
	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			tag_s1    <= '0;
			tag_s2    <= '0;
			pixel.tag <= '0;
		end else begin
			tag_s1    <= tag_in;
			tag_s2    <= tag_s1;
			pixel.tag <= tag_s2;
		end
	end

	// pen for the column from the row the ROM returns this cycle
	assign pen_sel = gfx_data[col_s2*3 +: 3];

	always_ff @(posedge clk_6m) begin
		// stage 1, pixel inside the tile
		fine_x_s1 <= plane_x[2:0];
		fine_y_s1 <= plane_y[2:0];
		// stage 2, row address and attributes
		gfx_addr  <= {entry_s1.code, fine_y_s1};
		col_s2    <= fine_x_s1;
		color_s2  <= entry_s1.color;
		prio_s2   <= entry_s1.prio;
		// stage 3, a disabled layer shows only pen 0
		pixel.pen   <= ctrl.enable ? pen_sel : pen_t'(0);
		pixel.color <= color_s2;
		pixel.prio  <= prio_s2;
	end

endmodule

`default_nettype wire

//--- verilog/tilegen_cfg.svh
`ifndef TILEGEN_CFG_SVH
`define TILEGEN_CFG_SVH

////////////////////
// raster geometry
////////////////////

// dots per line, visible dots first
`define TG_H_TOTAL        64
`define TG_H_VISIBLE      48
// lines per frame, visible lines first
`define TG_V_TOTAL        40
`define TG_V_VISIBLE      32
// hsync window in dots
`define TG_HSYNC_START    52
`define TG_HSYNC_LEN      4
// vsync covers this whole line
`define TG_VSYNC_LINE     36

////////////////////
// tile map
////////////////////

// map is square, in tiles
`define TG_MAP_TILES      8
// tile edge in pixels
`define TG_TILE_PIX       8

////////////////////
// cpu bus
////////////////////

`define TG_CPU_AW         9
`define TG_CPU_DW         16

// register offsets inside region 0
`define TG_REG_SCROLL_X0  0
`define TG_REG_SCROLL_Y0  1
`define TG_REG_SCROLL_X1  2
`define TG_REG_SCROLL_Y1  3
`define TG_REG_BACK_COLOR 4
`define TG_REG_CONTROL    5

// address bits 8:7 pick the region
`define TG_REGION_REGS    2'd0
`define TG_REGION_LAYER0  2'd1
`define TG_REGION_LAYER1  2'd2

// counters to output dot, in clocks
`define TG_PIPE_LATENCY   5

`endif

//--- verilog/tilegen_pkg.sv
`default_nettype none

package tilegen_pkg;

	////////////////////
	// plain vectors
	////////////////////

	// raster counters
	typedef logic [6:0] hpos_t;
	typedef logic [5:0] vpos_t;
	// scroll offset, the plane is 64 pixels and wraps
	typedef logic [5:0] scroll_t;
	typedef logic [7:0] tile_code_t;
	// palette bank
	typedef logic [4:0] color_t;
	typedef logic [2:0] prio_t;
	// pen 0 is transparent
	typedef logic [2:0] pen_t;
	// final colour index
	typedef logic [7:0] dot_t;
	typedef logic [5:0] map_index_t;
	// tile code above the row inside the tile
	typedef logic [10:0] gfx_addr_t;
	// pixel i in bits 3i+2 down to 3i
	typedef logic [23:0] gfx_row_t;

	////////////////////
	// bundles
	////////////////////

	// sync and blanking that ride with each dot
	typedef struct packed {
		logic active;
		logic hsync;
		logic vsync;
	} raster_tag_t;

	// one map word, same layout as the cpu data word
	typedef struct packed {
		tile_code_t code;
		color_t     color;
		prio_t      prio;
	} tile_entry_t;

	typedef struct packed {
		scroll_t scroll_x;
		scroll_t scroll_y;
		logic    enable;
	} layer_ctrl_t;

	// generator output
	typedef struct packed {
		raster_tag_t tag;
		pen_t        pen;
		color_t      color;
		prio_t       prio;
	} layer_pixel_t;

	// mixer chain pixel
	typedef struct packed {
		raster_tag_t tag;
		dot_t        dot;
		prio_t       prio;
	} mix_pixel_t;

endpackage

`default_nettype wire

//--- verilog/tilegen_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilegen_cfg.svh"

module tilegen_regs import tilegen_pkg::*; (
	input  wire                   clk_6m,
	input  wire                   rst_n,
	input  wire                   cpu_we,
	input  wire [`TG_CPU_AW-1:0]  cpu_addr,
	input  wire [`TG_CPU_DW-1:0]  cpu_data,
	output layer_ctrl_t           layer0_ctrl,
	output layer_ctrl_t           layer1_ctrl,
	output logic                  flip,
	output dot_t                  back_color,
	output logic                  map0_we,
	output logic                  map1_we,
	output map_index_t            map_addr,
	output tile_entry_t           map_data
);

	// top two address bits
	logic [1:0] region;
	// register offset in region 0
	logic [6:0] offset;
	logic       reg_we;

	////////////////////
	// address decode
	////////////////////

	assign region = cpu_addr[`TG_CPU_AW-1 -: 2];
	assign offset = cpu_addr[6:0];
	assign reg_we = cpu_we && (region == `TG_REGION_REGS);

	// map writes go straight to the generators, which own the RAMs
	assign map0_we  = cpu_we && (region == `TG_REGION_LAYER0);
	assign map1_we  = cpu_we && (region == `TG_REGION_LAYER1);
	assign map_addr = cpu_addr[5:0];
	// data word is already in tile entry layout
	assign map_data = cpu_data;

	////////////////////
	// register file
	////////////////////

	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			// both layers off, no scroll, black background
			layer0_ctrl <= '0;
			layer1_ctrl <= '0;
			flip        <= 1'b0;
			back_color  <= '0;
		end else if (reg_we) begin
			case (offset)
				`TG_REG_SCROLL_X0: layer0_ctrl.scroll_x <= cpu_data[5:0];
				`TG_REG_SCROLL_Y0: layer0_ctrl.scroll_y <= cpu_data[5:0];
				`TG_REG_SCROLL_X1: layer1_ctrl.scroll_x <= cpu_data[5:0];
				`TG_REG_SCROLL_Y1: layer1_ctrl.scroll_y <= cpu_data[5:0];
				`TG_REG_BACK_COLOR: back_color <= cpu_data[7:0];
				`TG_REG_CONTROL: begin
					// bit 0 flip, bits 1 and 2 layer enables
					flip                <= cpu_data[0];
					layer0_ctrl.enable  <= cpu_data[1];
					layer1_ctrl.enable  <= cpu_data[2];
				end
				// unused offsets are dropped
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/tilegen_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilegen_cfg.svh"

module tilegen_subsystem import tilegen_pkg::*; (
	input  wire                  clk_6m,
	input  wire                  rst_n,
	input  wire                  cpu_we,
	input  wire [`TG_CPU_AW-1:0] cpu_addr,
	input  wire [`TG_CPU_DW-1:0] cpu_data,
	output gfx_addr_t            gfx0_addr,
	input  gfx_row_t             gfx0_data,
	output gfx_addr_t            gfx1_addr,
	input  gfx_row_t             gfx1_data,
	output dot_t                 dot,
	output logic                 dot_valid,
	output logic                 hsync,
	output logic                 vsync
);

	// raster
	hpos_t        hcount;
	vpos_t        vcount;
	raster_tag_t  raster_tag;

	// registers
	layer_ctrl_t  layer0_ctrl;
	layer_ctrl_t  layer1_ctrl;
	logic         flip;
	dot_t         back_color;
	logic         map0_we;
	logic         map1_we;
	map_index_t   map_addr;
	tile_entry_t  map_data;

	// layers and mixer chain
	layer_pixel_t layer0_pixel;
	layer_pixel_t layer1_pixel;
	layer_pixel_t layer1_pixel_d;
	mix_pixel_t   back_pixel;
	mix_pixel_t   mix0_pixel;
	mix_pixel_t   mix1_pixel;

	video_timing u_video_timing (
		.clk_6m (clk_6m),
		.rst_n  (rst_n),
		.hcount (hcount),
		.vcount (vcount),
		.tag    (raster_tag)
	);

	tilegen_regs u_tilegen_regs (
		.clk_6m      (clk_6m),
		.rst_n       (rst_n),
		.cpu_we      (cpu_we),
		.cpu_addr    (cpu_addr),
		.cpu_data    (cpu_data),
		.layer0_ctrl (layer0_ctrl),
		.layer1_ctrl (layer1_ctrl),
		.flip        (flip),
		.back_color  (back_color),
		.map0_we     (map0_we),
		.map1_we     (map1_we),
		.map_addr    (map_addr),
		.map_data    (map_data)
	);

	////////////////////
	// tile layers
	////////////////////

	tile_scroll_gen u_layer0_gen (
		.clk_6m (clk_6m), .rst_n (rst_n),
		.hcount (hcount), .vcount (vcount), .tag_in (raster_tag),
		.ctrl (layer0_ctrl), .flip (flip),
		.map_we (map0_we), .map_addr (map_addr), .map_data (map_data),
		.gfx_addr (gfx0_addr), .gfx_data (gfx0_data),
		.pixel (layer0_pixel)
	);

	tile_scroll_gen u_layer1_gen (
		.clk_6m (clk_6m), .rst_n (rst_n),
		.hcount (hcount), .vcount (vcount), .tag_in (raster_tag),
		.ctrl (layer1_ctrl), .flip (flip),
		.map_we (map1_we), .map_addr (map_addr), .map_data (map_data),
		.gfx_addr (gfx1_addr), .gfx_data (gfx1_data),
		.pixel (layer1_pixel)
	);

	// layer 1 meets the chain one mixer later, so it waits one dot
	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			layer1_pixel_d <= '0;
		end else begin
			layer1_pixel_d <= layer1_pixel;
		end
	end

	////////////////////
	// priority chain
	////////////////////

	// background at lowest priority, tag taken from layer 0 so it lines up
	assign back_pixel.tag  = layer0_pixel.tag;
	assign back_pixel.dot  = back_color;
	assign back_pixel.prio = '0;

	tile_pixel_mixer u_mixer0 (
		.clk_6m (clk_6m), .rst_n (rst_n),
		.pixel_in (back_pixel), .layer (layer0_pixel),
		.pixel_out (mix0_pixel)
	);

	tile_pixel_mixer u_mixer1 (
		.clk_6m (clk_6m), .rst_n (rst_n),
		.pixel_in (mix0_pixel), .layer (layer1_pixel_d),
		.pixel_out (mix1_pixel)
	);

	// video out
	assign dot       = mix1_pixel.dot;
	assign dot_valid = mix1_pixel.tag.active;
	assign hsync     = mix1_pixel.tag.hsync;
	assign vsync     = mix1_pixel.tag.vsync;

endmodule

`default_nettype wire

//--- verilog/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilegen_cfg.svh"

module video_timing import tilegen_pkg::*; (
	input  wire         clk_6m,
	input  wire         rst_n,
	output hpos_t       hcount,
	output vpos_t       vcount,
	output raster_tag_t tag
);

	// next counter values
	hpos_t       h_next;
	vpos_t       v_next;
	// tag decoded from the next position so it lines up with the counters
	raster_tag_t tag_next;

	////////////////////
	// counters
	////////////////////

	always_comb begin
		h_next = hcount + 1'b1;
		v_next = vcount;
		// end of line wraps dot and steps line
		if (hcount == hpos_t'(`TG_H_TOTAL - 1)) begin
			h_next = '0;
			if (vcount == vpos_t'(`TG_V_TOTAL - 1)) begin
				v_next = '0;
			end else begin
				v_next = vcount + 1'b1;
			end
		end
	end

	////////////////////
	// sync decode
	////////////////////

	always_comb begin
		// visible area is the top left corner of the raster
		tag_next.active = (h_next < hpos_t'(`TG_H_VISIBLE)) &&
			(v_next < vpos_t'(`TG_V_VISIBLE));
		// hsync window inside horizontal blank
		tag_next.hsync = (h_next >= hpos_t'(`TG_HSYNC_START)) &&
			(h_next < hpos_t'(`TG_HSYNC_START + `TG_HSYNC_LEN));
		// vsync for one whole line
		tag_next.vsync = (v_next == vpos_t'(`TG_VSYNC_LINE));
	end

	// all outputs leave from flops
	always_ff @(posedge clk_6m) begin
		if (!rst_n) begin
			hcount <= '0;
			vcount <= '0;
			tag    <= '0;
		end else begin
			hcount <= h_next;
			vcount <= v_next;
			tag    <= tag_next;
		end
	end

endmodule

`default_nettype wire
